/* wb_subsys.f */
+incdir+design
design/wb_pkg.sv
design/ex2_wb_stage.sv
design/wb_regfile.sv
design/exc_csr_regs.sv
design/wb_subsys.sv
verif/wb_subsys_chk.sv
verif/tb_wb_subsys.sv

/* Makefile */
TOP := tb_wb_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f wb_subsys.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* verif/tb_wb_subsys.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module tb_wb_subsys;
    import wb_pkg::*;

    // the whole sequence runs in under 150 cycles, so this leaves a wide margin
    localparam int max_cycles = 2000;

    localparam uop_t uop_csr  = uop_t'(1 << `UOP_INS_CSR);
    localparam uop_t uop_quo  = uop_t'(1 << `UOP_INS_DIV);
    localparam uop_t uop_rem  = uop_t'((1 << `UOP_INS_DIV) | (1 << `UOP_COND_LO));
    localparam uop_t uop_load = uop_t'(1 << `UOP_INS_MEM);

    logic clk;
    logic aresetn;
    word_t pc0, pc1, inst0, inst1, result0, result1;
    uop_t uop0, uop1;
    logic result_valid0, result_valid1;
    reg_idx_t rd0, rd1, raddr0, raddr1;
    word_t quotient, remainder, dcache_data, csr_data, badv, era;
    logic div_ready, dcache_ready, csr_ready, exception_flag, cpu_interrupt, ertn;
    ecode_t ecode;
    logic allowin, flush, tlbr_mode;
    word_t rdata0, rdata1, dbg_pc0, dbg_pc1, dbg_inst0, dbg_inst1, dbg_wdata0, dbg_wdata1;
    logic [3:0] dbg_wen0, dbg_wen1;
    reg_idx_t dbg_wnum0, dbg_wnum1;
    ecode_t csr_ecode;
    word_t csr_badv, csr_era;
    vppn_t csr_vppn;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    // expected csr contents, kept across tests
    word_t exp_badv = '0;
    vppn_t exp_vppn = '0;

    wb_subsys uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ecode(input ecode_t got, input ecode_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vppn(input vppn_t got, input vppn_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        if (errors == e0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
        end
    endtask

    task automatic idle_inputs();
        result_valid0  = 1'b0;
        result_valid1  = 1'b0;
        uop0           = '0;
        uop1           = '0;
        csr_ready      = 1'b1;
        div_ready      = 1'b1;
        dcache_ready   = 1'b1;
        exception_flag = 1'b0;
        cpu_interrupt  = 1'b0;
        ertn           = 1'b0;
    endtask

    // returns on the next falling edge
    task automatic read_check(input reg_idx_t r, input word_t exp);
        raddr0 = r;
        raddr1 = r;
        #1;
        check_word(rdata0, exp, $sformatf("rdata0 of r%0d", r));
        check_word(rdata1, exp, $sformatf("rdata1 of r%0d", r));
        @(negedge clk);
    endtask

    task automatic check_trace(input int lane, input reg_idx_t rd, input word_t data);
        check_bit(lane == 1 ? &dbg_wen1 : &dbg_wen0, 1'b1, "dbg_wen all set");
        check_idx(lane == 1 ? dbg_wnum1 : dbg_wnum0, rd, "dbg_wnum");
        check_word(lane == 1 ? dbg_wdata1 : dbg_wdata0, data, "dbg_wdata");
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit(flush, 1'b0, "flush after reset");
        check_bit(|dbg_wen0, 1'b0, "dbg_wen0 after reset");
        check_bit(|dbg_wen1, 1'b0, "dbg_wen1 after reset");
        check_bit(tlbr_mode, 1'b0, "tlbr_mode after reset");
        for (int i = 0; i < `NUM_REGS; i++) begin
            read_check(reg_idx_t'(i), '0);
        end
        report_test("reset state", e0);
    endtask

    task automatic test_alu();
        int e0;
        reg_idx_t r0, r1;
        word_t d0, d1;
        e0 = errors;
        r0 = reg_idx_t'($urandom_range(1, 15));
        r1 = reg_idx_t'($urandom_range(16, 31));
        d0 = $urandom;
        d1 = $urandom;
        @(negedge clk);
        pc0 = $urandom;
        pc1 = $urandom;
        inst0 = $urandom;
        inst1 = $urandom;
        result0 = d0;
        result1 = d1;
        rd0 = r0;
        rd1 = r1;
        result_valid0 = 1'b1;
        result_valid1 = 1'b1;
        @(negedge clk);
        idle_inputs();
        check_word(dbg_pc0, pc0, "dbg_pc0");
        check_word(dbg_pc1, pc1, "dbg_pc1");
        check_word(dbg_inst0, inst0, "dbg_inst0");
        check_word(dbg_inst1, inst1, "dbg_inst1");
        check_trace(0, r0, d0);
        check_trace(1, r1, d1);
        @(negedge clk);
        read_check(r0, d0);
        read_check(r1, d1);
        report_test("alu writeback", e0);
    endtask

    // hold a slow op with only its own ready low, then release it
    task automatic slow_case(input int lane, input uop_t uop, input reg_idx_t rd,
                             input word_t exp, input string name);
        int e0;
        e0 = errors;
        @(negedge clk);
        if (uop[`UOP_INS_CSR]) begin
            csr_ready = 1'b0;
        end else if (uop[`UOP_INS_DIV]) begin
            div_ready = 1'b0;
        end else begin
            dcache_ready = 1'b0;
        end
        if (lane == 0) begin
            uop0 = uop;
            rd0 = rd;
        end else begin
            uop1 = uop;
            rd1 = rd;
        end
        #1;
        check_bit(allowin, 1'b0, "allowin while waiting");
        @(negedge clk);
        check_bit(lane == 1 ? |dbg_wen1 : |dbg_wen0, 1'b0, "write while waiting");
        csr_ready = 1'b1;
        div_ready = 1'b1;
        dcache_ready = 1'b1;
        #1;
        check_bit(allowin, 1'b1, "allowin once ready");
        @(negedge clk);
        idle_inputs();
        check_trace(lane, rd, exp);
        @(negedge clk);
        read_check(rd, exp);
        report_test(name, e0);
    endtask

    task automatic test_override();
        int e0;
        word_t d;
        e0 = errors;
        d = $urandom;
        @(negedge clk);
        uop0 = uop_csr;
        result0 = d;
        result_valid0 = 1'b1;
        rd0 = 5'd20;
        csr_ready = 1'b0;
        div_ready = 1'b0;
        dcache_ready = 1'b0;
        #1;
        check_bit(allowin, 1'b1, "allowin with result_valid");
        @(negedge clk);
        idle_inputs();
        check_trace(0, 5'd20, d);
        @(negedge clk);
        read_check(5'd20, d);
        report_test("result_valid override", e0);
    endtask

    task automatic test_conflict();
        int e0;
        reg_idx_t r;
        word_t d1;
        e0 = errors;
        r = reg_idx_t'($urandom_range(1, 31));
        d1 = $urandom;
        @(negedge clk);
        rd0 = r;
        rd1 = r;
        result0 = $urandom;
        result1 = d1;
        result_valid0 = 1'b1;
        result_valid1 = 1'b1;
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        read_check(r, d1);
        rd0 = '0;
        rd1 = '0;
        result0 = $urandom | 32'h1;
        result1 = $urandom | 32'h1;
        result_valid0 = 1'b1;
        result_valid1 = 1'b1;
        @(negedge clk);
        idle_inputs();
        check_bit(|dbg_wen0, 1'b0, "dbg_wen0 for r0");
        check_bit(|dbg_wen1, 1'b0, "dbg_wen1 for r0");
        @(negedge clk);
        read_check('0, '0);
        report_test("dual write and r0", e0);
    endtask

    task automatic raise_exception(input ecode_t code);
        word_t bv, ea;
        bv = $urandom;
        ea = $urandom;
        @(negedge clk);
        exception_flag = 1'b1;
        ecode = code;
        badv = bv;
        era = ea;
        @(negedge clk);
        idle_inputs();
        check_bit(flush, 1'b1, "flush after exception");
        @(negedge clk);
        check_bit(flush, 1'b0, "flush after one cycle");
        // every code raised here is an address fault
        exp_badv = bv;
        if (code != `EXP_ADEF && code != `EXP_ALE) begin
            exp_vppn = bv[31:13];
        end
        check_word(csr_era, ea, "csr_era");
        check_ecode(csr_ecode, code, "csr_ecode");
        check_word(csr_badv, exp_badv, "csr_badv");
        check_vppn(csr_vppn, exp_vppn, "csr_vppn");
    endtask

    task automatic test_exceptions();
        int e0;
        e0 = errors;
        raise_exception(`EXP_ADEF);
        report_test("exception adef", e0);
        e0 = errors;
        raise_exception(`EXP_PIL);
        report_test("exception pil", e0);
        e0 = errors;
        raise_exception(`EXP_ALE);
        report_test("exception ale", e0);
    endtask

    task automatic test_interrupt();
        int e0;
        word_t ea;
        e0 = errors;
        ea = $urandom;
        @(negedge clk);
        cpu_interrupt = 1'b1;
        ecode = '0;
        era = ea;
        badv = $urandom;
        @(negedge clk);
        idle_inputs();
        check_bit(flush, 1'b1, "flush after interrupt");
        @(negedge clk);
        check_bit(flush, 1'b0, "flush after one cycle");
        check_word(csr_era, ea, "csr_era after interrupt");
        check_word(csr_badv, exp_badv, "csr_badv after interrupt");
        report_test("interrupt", e0);
    endtask

    task automatic test_tlb_refill();
        int e0;
        e0 = errors;
        check_bit(tlbr_mode, 1'b0, "tlbr_mode before refill");
        raise_exception(`EXP_TLBR);
        check_bit(tlbr_mode, 1'b1, "tlbr_mode after refill");
        ertn = 1'b1;
        @(negedge clk);
        idle_inputs();
        check_bit(tlbr_mode, 1'b0, "tlbr_mode after ertn");
        report_test("tlb refill", e0);
    endtask

    initial begin
        void'($urandom(69106));
        clk = 1'b0;
        aresetn = 1'b0;
        {pc0, pc1, inst0, inst1, result0, result1} = '0;
        {rd0, rd1, raddr0, raddr1} = '0;
        {quotient, remainder, dcache_data, csr_data, badv, era} = '0;
        ecode = '0;
        idle_inputs();
        repeat (16) @(negedge clk);
        aresetn = 1'b1;
        test_reset();
        test_alu();
        quotient = $urandom;
        remainder = $urandom;
        dcache_data = $urandom;
        csr_data = $urandom;
        slow_case(0, uop_csr, 5'd3, csr_data, "lane0 csr");
        slow_case(0, uop_quo, 5'd4, quotient, "lane0 quotient");
        slow_case(0, uop_rem, 5'd6, remainder, "lane0 remainder");
        slow_case(0, uop_load, 5'd7, dcache_data, "lane0 load");
        slow_case(1, uop_quo, 5'd9, quotient, "lane1 quotient");
        slow_case(1, uop_rem, 5'd10, remainder, "lane1 remainder");
        slow_case(1, uop_load, 5'd11, dcache_data, "lane1 load");
        test_override();
        test_conflict();
        test_exceptions();
        test_interrupt();
        test_tlb_refill();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_chk.failures);
        if (errors == 0 && uut.u_chk.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verif/wb_subsys_chk.sv */
`timescale 1ns/1ps

module wb_subsys_chk (
    input logic              clk,
    input logic              aresetn,
    input logic              exception_flag,
    input logic              cpu_interrupt,
    input logic              flush,
    input logic              tlb_exception,
    input logic              tlbr_mode,
    input logic [3:0]        dbg_wen0,
    input logic [3:0]        dbg_wen1,
    input wb_pkg::reg_idx_t  dbg_wnum0,
    input wb_pkg::reg_idx_t  dbg_wnum1,
    input wb_pkg::word_t     dbg_wdata0,
    input wb_pkg::word_t     dbg_wdata1
);

    int failures = 0;

    // r0 never shows up as written with data
    no_r0_trace0: assert property (@(posedge clk) disable iff (!aresetn)
        !((dbg_wen0 != '0) && (dbg_wnum0 == '0) && (dbg_wdata0 != '0)))
        else begin
            failures++;
            $error("lane 0 traced a nonzero write to r0");
        end

    no_r0_trace1: assert property (@(posedge clk) disable iff (!aresetn)
        !((dbg_wen1 != '0) && (dbg_wnum1 == '0) && (dbg_wdata1 != '0)))
        else begin
            failures++;
            $error("lane 1 traced a nonzero write to r0");
        end

    flush_after_trap: assert property (@(posedge clk) disable iff (!aresetn)
        (exception_flag || cpu_interrupt) |=> flush)
        else begin
            failures++;
            $error("flush missing after exception or interrupt");
        end

    flush_only_on_trap: assert property (@(posedge clk) disable iff (!aresetn)
        !(exception_flag || cpu_interrupt) |=> !flush)
        else begin
            failures++;
            $error("flush without exception or interrupt");
        end

    tlbr_needs_cause: assert property (@(posedge clk) disable iff (!aresetn)
        $rose(tlbr_mode) |-> $past(tlb_exception))
        else begin
            failures++;
            $error("tlbr_mode rose without a tlb refill exception");
        end

endmodule

bind wb_subsys wb_subsys_chk u_chk (
    .clk            (clk),
    .aresetn        (aresetn),
    .exception_flag (exception_flag),
    .cpu_interrupt  (cpu_interrupt),
    .flush          (flush),
    .tlb_exception  (tlb_exception),
    .tlbr_mode      (tlbr_mode),
    .dbg_wen0       (dbg_wen0),
    .dbg_wen1       (dbg_wen1),
    .dbg_wnum0      (dbg_wnum0),
    .dbg_wnum1      (dbg_wnum1),
    .dbg_wdata0     (dbg_wdata0),
    .dbg_wdata1     (dbg_wdata1)
);

/* design/wb_subsys.sv */
`timescale 1ns/1ps

module wb_subsys (
    input  logic              clk,
    input  logic              aresetn,
    input  wb_pkg::word_t     pc0,
    input  wb_pkg::word_t     pc1,
    input  wb_pkg::word_t     inst0,
    input  wb_pkg::word_t     inst1,
    input  wb_pkg::uop_t      uop0,
    input  wb_pkg::uop_t      uop1,
    input  wb_pkg::word_t     result0,
    input  wb_pkg::word_t     result1,
    input  logic              result_valid0,
    input  logic              result_valid1,
    input  wb_pkg::reg_idx_t  rd0,
    input  wb_pkg::reg_idx_t  rd1,
    input  wb_pkg::word_t     quotient,
    input  wb_pkg::word_t     remainder,
    input  logic              div_ready,
    input  wb_pkg::word_t     dcache_data,
    input  logic              dcache_ready,
    input  wb_pkg::word_t     csr_data,
    input  logic              csr_ready,
    input  logic              exception_flag,
    input  wb_pkg::ecode_t    ecode,
    input  wb_pkg::word_t     badv,
    input  wb_pkg::word_t     era,
    input  logic              cpu_interrupt,
    input  logic              ertn,
    input  wb_pkg::reg_idx_t  raddr0,
    input  wb_pkg::reg_idx_t  raddr1,
    output logic              allowin,
    output logic              flush,
    output wb_pkg::word_t     rdata0,
    output wb_pkg::word_t     rdata1,
    output wb_pkg::word_t     dbg_pc0,
    output wb_pkg::word_t     dbg_pc1,
    output wb_pkg::word_t     dbg_inst0,
    output wb_pkg::word_t     dbg_inst1,
    output logic [3:0]        dbg_wen0,
    output logic [3:0]        dbg_wen1,
    output wb_pkg::reg_idx_t  dbg_wnum0,
    output wb_pkg::reg_idx_t  dbg_wnum1,
    output wb_pkg::word_t     dbg_wdata0,
    output wb_pkg::word_t     dbg_wdata1,
    output wb_pkg::ecode_t    csr_ecode,
    output wb_pkg::word_t     csr_badv,
    output wb_pkg::word_t     csr_era,
    output wb_pkg::vppn_t     csr_vppn,
    output logic              tlbr_mode
);
    import wb_pkg::*;

    // stage to regfile
    word_t    wb_data0;
    word_t    wb_data1;
    reg_idx_t wb_rd0;
    reg_idx_t wb_rd1;
    logic     wb_we0;
    logic     wb_we1;

    // stage to exception csrs
    ecode_t   ecode_q;
    word_t    badv_q;
    word_t    era_q;
    vppn_t    vppn_q;
    logic     wen_badv;
    logic     wen_era;
    logic     wen_vppn;
    logic     tlb_exception;

    ex2_wb_stage u_stage (
        .clk            (clk),
        .aresetn        (aresetn),
        .pc0            (pc0),
        .pc1            (pc1),
        .inst0          (inst0),
        .inst1          (inst1),
        .uop0           (uop0),
        .uop1           (uop1),
        .result0        (result0),
        .result1        (result1),
        .result_valid0  (result_valid0),
        .result_valid1  (result_valid1),
        .rd0            (rd0),
        .rd1            (rd1),
        .quotient       (quotient),
        .remainder      (remainder),
        .div_ready      (div_ready),
        .dcache_data    (dcache_data),
        .dcache_ready   (dcache_ready),
        .csr_data       (csr_data),
        .csr_ready      (csr_ready),
        .exception_flag (exception_flag),
        .ecode          (ecode),
        .badv           (badv),
        .era            (era),
        .cpu_interrupt  (cpu_interrupt),
        .allowin        (allowin),
        .flush          (flush),
        .wb_data0       (wb_data0),
        .wb_data1       (wb_data1),
        .wb_rd0         (wb_rd0),
        .wb_rd1         (wb_rd1),
        .wb_we0         (wb_we0),
        .wb_we1         (wb_we1),
        .ecode_q        (ecode_q),
        .badv_q         (badv_q),
        .era_q          (era_q),
        .vppn_q         (vppn_q),
        .wen_badv       (wen_badv),
        .wen_era        (wen_era),
        .wen_vppn       (wen_vppn),
        .tlb_exception  (tlb_exception),
        .dbg_pc0        (dbg_pc0),
        .dbg_pc1        (dbg_pc1),
        .dbg_inst0      (dbg_inst0),
        .dbg_inst1      (dbg_inst1),
        .dbg_wen0       (dbg_wen0),
        .dbg_wen1       (dbg_wen1),
        .dbg_wnum0      (dbg_wnum0),
        .dbg_wnum1      (dbg_wnum1),
        .dbg_wdata0     (dbg_wdata0),
        .dbg_wdata1     (dbg_wdata1)
    );

    wb_regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (wb_we0),
        .we1     (wb_we1),
        .waddr0  (wb_rd0),
        .waddr1  (wb_rd1),
        .wdata0  (wb_data0),
        .wdata1  (wb_data1),
        .raddr0  (raddr0),
        .raddr1  (raddr1),
        .rdata0  (rdata0),
        .rdata1  (rdata1)
    );

    exc_csr_regs u_csr (
        .clk           (clk),
        .aresetn       (aresetn),
        .ecode_q       (ecode_q),
        .badv_q        (badv_q),
        .era_q         (era_q),
        .vppn_q        (vppn_q),
        .wen_badv      (wen_badv),
        .wen_era       (wen_era),
        .wen_vppn      (wen_vppn),
        .tlb_exception (tlb_exception),
        .ertn          (ertn),
        .csr_ecode     (csr_ecode),
        .csr_badv      (csr_badv),
        .csr_era       (csr_era),
        .csr_vppn      (csr_vppn),
        .tlbr_mode     (tlbr_mode)
    );

endmodule

/* design/exc_csr_regs.sv */
`timescale 1ns/1ps

module exc_csr_regs (
    input  logic            clk,
    input  logic            aresetn,
    input  wb_pkg::ecode_t  ecode_q,
    input  wb_pkg::word_t   badv_q,
    input  wb_pkg::word_t   era_q,
    input  wb_pkg::vppn_t   vppn_q,
    input  logic            wen_badv,
    input  logic            wen_era,
    input  logic            wen_vppn,
    input  logic            tlb_exception,
    input  logic            ertn,
    output wb_pkg::ecode_t  csr_ecode,
    output wb_pkg::word_t   csr_badv,
    output wb_pkg::word_t   csr_era,
    output wb_pkg::vppn_t   csr_vppn,
    output logic            tlbr_mode
);

    // estat ecode and era move together on any trap
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            csr_ecode <= '0;
            csr_era   <= '0;
        end else if (wen_era) begin
            csr_ecode <= ecode_q;
            csr_era   <= era_q;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            csr_badv <= '0;
        end else if (wen_badv) begin
            csr_badv <= badv_q;
        end
    end

    // tlbehi vppn
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            csr_vppn <= '0;
        end else if (wen_vppn) begin
            csr_vppn <= vppn_q;
        end
    end

    // refill entry wins over a same-cycle ertn
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            tlbr_mode <= 1'b0;
        end else if (tlb_exception) begin
            tlbr_mode <= 1'b1;
        end else if (ertn) begin
            tlbr_mode <= 1'b0;
        end
    end

endmodule

/* design/wb_regfile.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_regfile (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              we0,
    input  logic              we1,
    input  wb_pkg::reg_idx_t  waddr0,
    input  wb_pkg::reg_idx_t  waddr1,
    input  wb_pkg::word_t     wdata0,
    input  wb_pkg::word_t     wdata1,
    input  wb_pkg::reg_idx_t  raddr0,
    input  wb_pkg::reg_idx_t  raddr1,
    output wb_pkg::word_t     rdata0,
    output wb_pkg::word_t     rdata1
);
    import wb_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && (waddr0 != '0)) begin
                regs[waddr0] <= wdata0;
            end
            // lane 1 is younger, its write lands last
            if (we1 && (waddr1 != '0)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // r0 is hardwired zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* design/ex2_wb_stage.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module ex2_wb_stage (
    input  logic              clk,
    input  logic              aresetn,
    input  wb_pkg::word_t     pc0,
    input  wb_pkg::word_t     pc1,
    input  wb_pkg::word_t     inst0,
    input  wb_pkg::word_t     inst1,
    input  wb_pkg::uop_t      uop0,
    input  wb_pkg::uop_t      uop1,
    input  wb_pkg::word_t     result0,
    input  wb_pkg::word_t     result1,
    input  logic              result_valid0,
    input  logic              result_valid1,
    input  wb_pkg::reg_idx_t  rd0,
    input  wb_pkg::reg_idx_t  rd1,
    input  wb_pkg::word_t     quotient,
    input  wb_pkg::word_t     remainder,
    input  logic              div_ready,
    input  wb_pkg::word_t     dcache_data,
    input  logic              dcache_ready,
    input  wb_pkg::word_t     csr_data,
    input  logic              csr_ready,
    input  logic              exception_flag,
    input  wb_pkg::ecode_t    ecode,
    input  wb_pkg::word_t     badv,
    input  wb_pkg::word_t     era,
    input  logic              cpu_interrupt,
    output logic              allowin,
    output logic              flush,
    output wb_pkg::word_t     wb_data0,
    output wb_pkg::word_t     wb_data1,
    output wb_pkg::reg_idx_t  wb_rd0,
    output wb_pkg::reg_idx_t  wb_rd1,
    output logic              wb_we0,
    output logic              wb_we1,
    output wb_pkg::ecode_t    ecode_q,
    output wb_pkg::word_t     badv_q,
    output wb_pkg::word_t     era_q,
    output wb_pkg::vppn_t     vppn_q,
    output logic              wen_badv,
    output logic              wen_era,
    output logic              wen_vppn,
    output logic              tlb_exception,
    output wb_pkg::word_t     dbg_pc0,
    output wb_pkg::word_t     dbg_pc1,
    output wb_pkg::word_t     dbg_inst0,
    output wb_pkg::word_t     dbg_inst1,
    output logic [3:0]        dbg_wen0,
    output logic [3:0]        dbg_wen1,
    output wb_pkg::reg_idx_t  dbg_wnum0,
    output wb_pkg::reg_idx_t  dbg_wnum1,
    output wb_pkg::word_t     dbg_wdata0,
    output wb_pkg::word_t     dbg_wdata1
);
    import wb_pkg::*;

    logic  ready0;
    logic  ready1;
    logic  has_src0;
    logic  has_src1;
    word_t pick0;
    word_t pick1;
    logic  page_exc;
    logic  addr_exc;

    // memory op with the store bit clear
    function automatic logic is_load(input uop_t uop);
        logic [`UOP_COND_W-1:0] cond;
        cond = uop[`UOP_COND_LO +: `UOP_COND_W];
        is_load = uop[`UOP_INS_MEM] && !cond[`COND_STORE];
    endfunction

    // value comes from csr, divider or dcache
    function automatic logic needs_slow(input uop_t uop, input logic csr_lane);
        needs_slow = (csr_lane && uop[`UOP_INS_CSR]) || uop[`UOP_INS_DIV] || is_load(uop);
    endfunction

    function automatic logic lane_ready(input uop_t uop, input logic rv, input logic csr_lane);
        if (rv) begin
            lane_ready = 1'b1;
        end else if (csr_lane && uop[`UOP_INS_CSR]) begin
            lane_ready = csr_ready;
        end else if (uop[`UOP_INS_DIV]) begin
            lane_ready = div_ready;
        end else if (is_load(uop)) begin
            lane_ready = dcache_ready;
        end else begin
            lane_ready = 1'b1;
        end
    endfunction

    // same priority order as lane_ready
    function automatic word_t lane_data(input uop_t uop, input logic rv, input word_t result,
                                        input logic csr_lane);
        logic [`UOP_COND_W-1:0] cond;
        cond = uop[`UOP_COND_LO +: `UOP_COND_W];
        if (rv) begin
            lane_data = result;
        end else if (csr_lane && uop[`UOP_INS_CSR]) begin
            lane_data = csr_data;
        end else if (uop[`UOP_INS_DIV]) begin
            lane_data = cond[`COND_REM] ? remainder : quotient;
        end else if (is_load(uop)) begin
            lane_data = dcache_data;
        end else begin
            lane_data = '0;
        end
    endfunction

    // only lane 0 issues csr ops
    assign ready0   = lane_ready(uop0, result_valid0, 1'b1);
    assign ready1   = lane_ready(uop1, result_valid1, 1'b0);
    assign has_src0 = result_valid0 || needs_slow(uop0, 1'b1);
    assign has_src1 = result_valid1 || needs_slow(uop1, 1'b0);
    assign pick0    = lane_data(uop0, result_valid0, result0, 1'b1);
    assign pick1    = lane_data(uop1, result_valid1, result1, 1'b0);

    assign allowin = ready0 && ready1;

    // a pair moves on together, so neither lane writes while the other waits
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb_we0   <= 1'b0;
            wb_we1   <= 1'b0;
            wb_rd0   <= '0;
            wb_rd1   <= '0;
            wb_data0 <= '0;
            wb_data1 <= '0;
        end else begin
            wb_we0   <= has_src0 && allowin;
            wb_we1   <= has_src1 && allowin;
            wb_rd0   <= has_src0 ? rd0 : '0;
            wb_rd1   <= has_src1 ? rd1 : '0;
            wb_data0 <= pick0;
            wb_data1 <= pick1;
        end
    end

    // tlb-side faults carry a page number
    assign page_exc = ecode inside {`EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME, `EXP_PPI,
                                    `EXP_TLBR};
    assign addr_exc = page_exc || (ecode == `EXP_ADEF) || (ecode == `EXP_ALE);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush         <= 1'b0;
            wen_era       <= 1'b0;
            wen_badv      <= 1'b0;
            wen_vppn      <= 1'b0;
            tlb_exception <= 1'b0;
        end else begin
            flush         <= exception_flag || cpu_interrupt;
            wen_era       <= exception_flag || cpu_interrupt;
            wen_badv      <= exception_flag && addr_exc;
            wen_vppn      <= exception_flag && page_exc;
            tlb_exception <= exception_flag && (ecode == `EXP_TLBR);
        end
    end

    always_ff @(posedge clk) begin
        ecode_q <= ecode;
        badv_q  <= badv;
        era_q   <= era;
        vppn_q  <= badv[31:13];
    end

    // trace lines up with the registered writeback
    always_ff @(posedge clk) begin
        dbg_pc0   <= pc0;
        dbg_pc1   <= pc1;
        dbg_inst0 <= inst0;
        dbg_inst1 <= inst1;
    end

    // r0 writes are dropped by the regfile, so they are not traced either
    assign dbg_wen0   = {4{wb_we0 && (wb_rd0 != '0)}};
    assign dbg_wen1   = {4{wb_we1 && (wb_rd1 != '0)}};
    assign dbg_wnum0  = wb_rd0;
    assign dbg_wnum1  = wb_rd1;
    assign dbg_wdata0 = wb_data0;
    assign dbg_wdata1 = wb_data1;

endmodule

/* design/wb_pkg.sv */
package wb_pkg;

    // data, pc and instruction words
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // exception code as carried down the pipe
    typedef logic [6:0] ecode_t;

    // virtual page number, badv[31:13]
    typedef logic [18:0] vppn_t;

    // micro-op flags, bit layout in wb_consts.svh
    typedef logic [7:0] uop_t;

endpackage

/* design/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// uop flag positions
`define UOP_INS_CSR 0
`define UOP_INS_DIV 1
`define UOP_INS_MEM 2

// condition field, four bits from here up
`define UOP_COND_LO 3
`define UOP_COND_W  4

// cond bit meanings inside the field
`define COND_REM    0
`define COND_STORE  2

// exception codes
`define EXP_PIL  7'h01
`define EXP_PIS  7'h02
`define EXP_PIF  7'h03
`define EXP_PME  7'h04
`define EXP_PPI  7'h07
`define EXP_ADEF 7'h08
`define EXP_ALE  7'h09
`define EXP_TLBR 7'h3F

// architectural register count
`define NUM_REGS 32

`endif
